/* common/hamming_cfg.svh */
// ----------------------------------------------------------------------
// Width macros for the Hamming link
// Data width, parity width and the resulting block width
// ----------------------------------------------------------------------

`ifndef HAMMING_CFG_SVH
`define HAMMING_CFG_SVH

// Payload bits per word
`define HAMMING_DATA_WIDTH 8

// Smallest parity count with 2**P >= data + parity + 1
`define HAMMING_PARITY_WIDTH 4

// Data and parity together
`define HAMMING_BLOCK_WIDTH (`HAMMING_DATA_WIDTH + `HAMMING_PARITY_WIDTH)

`endif

/* common/hamming_types_pkg.sv */
// ----------------------------------------------------------------------
// Hamming code types
// Width typedefs and the block pack / unpack functions
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

package hamming_types_pkg;

  typedef logic [`HAMMING_DATA_WIDTH-1:0]   data_t;
  typedef logic [`HAMMING_PARITY_WIDTH-1:0] code_t;
  typedef logic [`HAMMING_BLOCK_WIDTH-1:0]  block_t;
  // Faulty block position, zero when clean
  typedef logic [`HAMMING_PARITY_WIDTH-1:0] syndrome_t;

  // Powers of two take parity bits, the rest take data in ascending order
  // Block position p lives at bit index p-1
  function automatic block_t pack_block(data_t data, code_t code);
    block_t block;
    int     d_idx;
    int     p_idx;
    d_idx = 0;
    p_idx = 0;
    for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        block[pos-1] = code[p_idx];
        p_idx++;
      end else begin
        block[pos-1] = data[d_idx];
        d_idx++;
      end
    end
    return block;
  endfunction

  // Inverse of pack_block
  function automatic void unpack_block(input block_t block, output data_t data,
                                       output code_t code);
    int d_idx;
    int p_idx;
    d_idx = 0;
    p_idx = 0;
    for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        code[p_idx] = block[pos-1];
        p_idx++;
      end else begin
        data[d_idx] = block[pos-1];
        d_idx++;
      end
    end
  endfunction

endpackage

/* common/hamming_stream_pkg.sv */
// ----------------------------------------------------------------------
// Beat formats carried on the link streams
// Input beat with fault mask, coded beat, corrected output beat
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

package hamming_stream_pkg;

  import hamming_types_pkg::*;

  // Word to send, plus block positions to invert in the channel
  typedef struct packed {
    data_t  data;
    block_t flip_mask;
  } in_beat_t;

  // Possibly faulted word and parity as seen after the channel
  typedef struct packed {
    data_t data;
    code_t code;
  } coded_beat_t;

  // Repaired word, error high when a bit was flipped back
  typedef struct packed {
    data_t data;
    logic  error;
  } out_beat_t;

endpackage

/* encoder/hamming_encoder.sv */
// ----------------------------------------------------------------------
// Hamming parity generator
// Combinational, one code word per data word
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

module hamming_encoder
  import hamming_types_pkg::*;
(
  input  data_t data,
  output code_t code
);

  // Data placed at its block positions, parity slots left at zero
  block_t data_block;

  assign data_block = pack_block(data, '0);

  // Parity bit k covers every position whose index has bit k set
  always_comb begin
    code = '0;
    for (int k = 0; k < `HAMMING_PARITY_WIDTH; k++) begin
      for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
        if (pos[k]) begin
          code[k] = code[k] ^ data_block[pos-1];
        end
      end
    end
  end

endmodule

/* encoder/hamming_encode_stage.sv */
// ----------------------------------------------------------------------
// Encode register stage
// Parity generation, channel fault injection and one valid/ready slot
// ----------------------------------------------------------------------

module hamming_encode_stage
  import hamming_types_pkg::*;
  import hamming_stream_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  in_beat_t    in_beat,
  input  logic        in_valid,
  output logic        in_ready,
  output coded_beat_t coded_beat,
  output logic        coded_valid,
  input  logic        coded_ready
);

  code_t       in_code;
  block_t      faulted_block;
  coded_beat_t faulted_beat;

  hamming_encoder i_encoder (
    .data (in_beat.data),
    .code (in_code)
  );

  // Build the clean block, then invert the masked positions
  always_comb begin
    faulted_block = pack_block(in_beat.data, in_code) ^ in_beat.flip_mask;
    unpack_block(faulted_block, faulted_beat.data, faulted_beat.code);
  end

  // Slot free, or drained this same cycle
  assign in_ready = !coded_valid || coded_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      coded_valid <= 1'b0;
    end else if (in_ready) begin
      coded_valid <= in_valid;
    end
  end

  // Payload only moves on an accepted input
  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      coded_beat <= faulted_beat;
    end
  end

  // A stalled beat stays put until the correct stage takes it
  a_coded_stable: assert property (
    @(posedge clock) disable iff (reset)
    coded_valid && !coded_ready |=> coded_valid && $stable(coded_beat)
  );

endmodule

/* corrector/hamming_block_corrector.sv */
// ----------------------------------------------------------------------
// Single-bit corrector on a packed Hamming block
// Syndrome from set positions, flip of the addressed bit
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

module hamming_block_corrector
  import hamming_types_pkg::*;
(
  input  block_t block,
  output logic   error,
  output block_t corrected_block
);

  syndrome_t syndrome;

  // XOR of the indices of all set positions, zero for a valid block
  always_comb begin
    syndrome = '0;
    for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
      if (block[pos-1]) begin
        syndrome = syndrome ^ syndrome_t'(pos);
      end
    end
  end

  assign error = |syndrome;

  // Flip only the position named by the syndrome
  always_comb begin
    for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
      corrected_block[pos-1] = block[pos-1] ^ (syndrome == syndrome_t'(pos));
    end
  end

  // Positions past the block mean a multi-bit fault the code cannot place
  always_comb begin
    if (!$isunknown(syndrome)) begin
      a_syndrome_range: assert (int'(syndrome) <= `HAMMING_BLOCK_WIDTH);
    end
  end

endmodule

/* corrector/hamming_corrector.sv */
// ----------------------------------------------------------------------
// Hamming data corrector
// Pads data, packs the block, repairs one bit, extracts the data
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

module hamming_corrector
  import hamming_types_pkg::*;
(
  input  data_t data,
  input  code_t code,
  output logic  error,
  output data_t corrected_data
);

  // Full message length that this many parity bits can protect
  localparam int PAD_DATA_WIDTH =
    (1 << `HAMMING_PARITY_WIDTH) - `HAMMING_PARITY_WIDTH - 1;

  logic [PAD_DATA_WIDTH-1:0] data_padded;
  block_t                    block;
  block_t                    corrected_block;

  // Upper padding is zero so it adds nothing to the syndrome
  assign data_padded = {{(PAD_DATA_WIDTH - `HAMMING_DATA_WIDTH){1'b0}}, data};

  // Padding positions sit above the block, only the real data is placed
  assign block = pack_block(data_padded[`HAMMING_DATA_WIDTH-1:0], code);

  hamming_block_corrector i_block_corrector (
    .block           (block),
    .error           (error),
    .corrected_block (corrected_block)
  );

  // Drop the repaired parity, keep the low data bits
  always_comb begin
    code_t corrected_code;
    unpack_block(corrected_block, corrected_data, corrected_code);
  end

endmodule

/* hdl/hamming_correct_stage.sv */
// ----------------------------------------------------------------------
// Correct register stage
// Single-bit repair and one valid/ready slot for the output beat
// ----------------------------------------------------------------------

module hamming_correct_stage
  import hamming_types_pkg::*;
  import hamming_stream_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  coded_beat_t coded_beat,
  input  logic        coded_valid,
  output logic        coded_ready,
  output out_beat_t   out_beat,
  output logic        out_valid,
  input  logic        out_ready
);

  logic  fix_error;
  data_t fix_data;

  hamming_corrector i_corrector (
    .data           (coded_beat.data),
    .code           (coded_beat.code),
    .error          (fix_error),
    .corrected_data (fix_data)
  );

  // Accept when empty or when the held beat leaves now
  assign coded_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (coded_ready) begin
      out_valid <= coded_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (coded_valid && coded_ready) begin
      out_beat.data  <= fix_data;
      out_beat.error <= fix_error;
    end
  end

  // Output held steady under back-pressure
  a_out_stable: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

/* hdl/hamming_ecc_link.sv */
// ----------------------------------------------------------------------
// Hamming-protected link top level
// Encode stage feeding the correct stage
// ----------------------------------------------------------------------

module hamming_ecc_link
  import hamming_stream_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  in_beat_t  in_beat,
  input  logic      in_valid,
  output logic      in_ready,
  output out_beat_t out_beat,
  output logic      out_valid,
  input  logic      out_ready
);

  // Channel between the two stages
  coded_beat_t coded_beat;
  logic        coded_valid;
  logic        coded_ready;

  hamming_encode_stage i_encode_stage (
    .clock       (clock),
    .reset       (reset),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .coded_beat  (coded_beat),
    .coded_valid (coded_valid),
    .coded_ready (coded_ready)
  );

  hamming_correct_stage i_correct_stage (
    .clock       (clock),
    .reset       (reset),
    .coded_beat  (coded_beat),
    .coded_valid (coded_valid),
    .coded_ready (coded_ready),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

/* verification/hamming_ecc_link_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the Hamming-protected link
// Clock, reset, stimulus tasks, scoreboard queue
// Concurrent checks on output data, latency and stall stability
// ----------------------------------------------------------------------

`include "hamming_cfg.svh"

module hamming_ecc_link_tb
  import hamming_types_pkg::*;
  import hamming_stream_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic      clock = 1'b0;
  logic      reset;
  in_beat_t  in_beat;
  logic      in_valid;
  logic      in_ready;
  out_beat_t out_beat;
  logic      out_valid;
  logic      out_ready = 1'b1;

  // Scoreboard state
  out_beat_t exp_q[$];
  out_beat_t head_beat;
  logic      sb_empty = 1'b1;
  int        errors = 0;
  int        checked = 0;
  int        tests_run = 0;
  int        errors_at_start;

  // Test control flags
  logic      check_latency = 1'b0;
  logic      toggle_ready = 1'b0;

  hamming_ecc_link i_dut (
    .clock     (clock),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // 40 ns period
  always #20 clock = ~clock;

  // Sink side, held high unless a test asks for back-pressure
  always @(posedge clock) begin
    out_ready <= toggle_ready ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  // Same data back, error flagged only for a single flipped bit
  function automatic out_beat_t expected_out(input in_beat_t beat);
    out_beat_t result;
    result.data  = beat.data;
    result.error = ($countones(beat.flip_mask) == 1);
    return result;
  endfunction

  // Pop on output transfer first, then push the newly accepted word
  always @(posedge clock) begin
    if (!reset) begin
      if (out_valid && out_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        checked++;
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_out(in_beat));
      end
    end
    sb_empty = (exp_q.size() == 0);
    if (!sb_empty) begin
      head_beat = exp_q[0];
    end
  end

  // Idle state right after reset
  a_reset_state: assert property (
    @(posedge clock) $fell(reset) |-> !out_valid && in_ready
  ) else begin
    errors++;
    $display("Mismatch at %0t: out_valid=%b in_ready=%b after reset", $time, out_valid,
             in_ready);
  end

  // Every delivered beat matches the oldest accepted word
  a_out_match: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && out_ready |-> !sb_empty && out_beat == head_beat
  ) else begin
    errors++;
    $display("Mismatch at %0t: got data %h error %b, expected data %h error %b (empty %b)",
             $time, out_beat.data, out_beat.error, head_beat.data, head_beat.error,
             sb_empty);
  end

  // Two cycles from acceptance to output with the sink always ready
  a_latency: assert property (
    @(posedge clock) disable iff (reset)
    $past(check_latency && in_valid && in_ready, 2) |-> out_valid
  ) else begin
    errors++;
    $display("Latency error at %0t: accepted word missing at the output two cycles later",
             $time);
  end

  // Stalled output keeps its value
  a_out_stable: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  ) else begin
    errors++;
    $display("Mismatch at %0t: out_beat changed or vanished while stalled", $time);
  end

  task automatic abort_run(input string reason);
    errors++;
    $display("Timeout at %0t: %s", $time, reason);
    $display("Tests run %0d, beats checked %0d, errors %0d", tests_run, checked, errors);
    $display("Done: errors found");
    $finish;
  endtask

  // Called on a rising edge, returns on the edge of the transfer
  task automatic send_word(input data_t data, input block_t mask);
    int   cycles;
    logic ready_seen;
    cycles = 0;
    in_beat.data      <= data;
    in_beat.flip_mask <= mask;
    in_valid          <= 1'b1;
    do begin
      @(negedge clock);
      ready_seen = in_ready;
      @(posedge clock);
      cycles++;
      if (!ready_seen && cycles > WAIT_LIMIT) begin
        abort_run("in_ready never rose for a pending word");
      end
    end while (!ready_seen);
    in_valid <= 1'b0;
  endtask

  // Wait until every accepted word has left the link
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (exp_q.size() != 0 && cycles > WAIT_LIMIT) begin
        abort_run("words still inside the link, output never delivered them");
      end
    end while (exp_q.size() != 0);
    @(posedge clock);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %0d %s finished with %0d errors", tests_run, name,
             errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    int gap;
    block_t mask;
    void'($urandom(60));
    reset    <= 1'b1;
    in_valid <= 1'b0;
    in_beat  <= '0;
    errors_at_start = 0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);
    finish_test("reset state");

    // Clean words, back to back
    check_latency <= 1'b1;
    send_word(8'h00, '0);
    send_word(8'hff, '0);
    send_word(8'ha5, '0);
    send_word(8'h5a, '0);
    for (int i = 0; i < 4; i++) begin
      send_word(data_t'($urandom()), '0);
    end
    wait_drained();
    finish_test("clean words");

    // Every non power of two position carries data
    for (int pos = 1; pos <= `HAMMING_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        send_word(data_t'($urandom()), block_t'(1) << (pos - 1));
      end
    end
    wait_drained();
    finish_test("single data-bit flips");

    // Parity positions 1, 2, 4, 8
    for (int k = 0; k < `HAMMING_PARITY_WIDTH; k++) begin
      send_word(data_t'($urandom()), block_t'(1) << ((1 << k) - 1));
    end
    wait_drained();
    check_latency <= 1'b0;
    finish_test("single parity-bit flips");

    // Random traffic with input gaps and sink back-pressure
    toggle_ready <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) @(posedge clock);
      mask = '0;
      if ($urandom_range(0, 1) != 0) begin
        mask = block_t'(1) << $urandom_range(0, `HAMMING_BLOCK_WIDTH - 1);
      end
      send_word(data_t'($urandom()), mask);
    end
    wait_drained();
    toggle_ready <= 1'b0;
    repeat (2) @(posedge clock);
    finish_test("random traffic with stalls");

    $display("Tests run %0d, beats checked %0d, errors %0d", tests_run, checked, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/hamming_types_pkg.sv
common/hamming_stream_pkg.sv
encoder/hamming_encoder.sv
encoder/hamming_encode_stage.sv
corrector/hamming_block_corrector.sv
corrector/hamming_corrector.sv
hdl/hamming_correct_stage.sv
hdl/hamming_ecc_link.sv
verification/hamming_ecc_link_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the Hamming link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f list.f \
  --top-module hamming_ecc_link_tb -o hamming_ecc_link_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/hamming_ecc_link_sim > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
